// ==== Makefile ====
TOP := bp_boot_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): bp_boot.f verilog/*.sv verilog/*.svh sim/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f bp_boot.f

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f bp_boot.f

clean:
	rm -rf obj_dir

// ==== bp_boot.f ====
+incdir+verilog
verilog/bp_boot_pkg.sv
verilog/bp_boot_cfg_loader.sv
verilog/bp_boot_nbf_loader.sv
verilog/bp_boot_io_router.sv
verilog/bp_boot_cfg_regs.sv
verilog/bp_boot_mem.sv
verilog/bp_boot_top.sv
sim/bp_boot_assert.sv
sim/bp_boot_tb.sv

// ==== sim/bp_boot_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module bp_boot_assert
   (
   input logic clk_i,
   input logic rst_i,
   input logic cfg_cmd_v_i,
   input logic nbf_cmd_v_i,
   input logic nbf_v_i,
   input logic nbf_full_i,
   input logic cfg_done_i,
   input logic freeze_i
   );

   // Router relies on the loaders never overlapping
   loaders_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
      !(cfg_cmd_v_i && nbf_cmd_v_i))
   else
      $error("both loader command valids high in the same cycle");

   nbf_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
      !(nbf_v_i && nbf_full_i))
   else
      $error("NBF record strobed while the record FIFO is full");

   // Config hand-over is one way, and the core stays frozen until then
   boot_order: assert property (@(posedge clk_i) disable iff (rst_i)
      !$fell(cfg_done_i) && (!$fell(freeze_i) || cfg_done_i))
   else
      $error("cfg_done fell, or freeze cleared before config finished");

endmodule

bind bp_boot_top bp_boot_assert bp_boot_assert_inst
   (
   .clk_i       (clk_i),
   .rst_i       (rst_i),
   .cfg_cmd_v_i (cfg_cmd_v),
   .nbf_cmd_v_i (nbf_cmd_v),
   .nbf_v_i     (nbf_v_i),
   .nbf_full_i  (nbf_full_o),
   .cfg_done_i  (cfg_done_o),
   .freeze_i    (freeze_o)
   );

`default_nettype wire

// ==== sim/bp_boot_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_boot_params.svh"

module bp_boot_tb;

   localparam int n_rec   = 40;
   localparam int max_pre = 12;
   localparam int max_gap = 4;
   localparam int n_extra = 3;
   localparam int watchdog_cycles = 5 + 20 + n_rec * max_gap + n_extra
                                    + `BP_BOOT_MEM_ELS + `BP_BOOT_INSTR_ELS + 200;

   logic                    clk_i;
   logic                    rst_i;
   logic                    nbf_v_i;
   bp_boot_pkg::addr_t      nbf_addr_i;
   bp_boot_pkg::data_t      nbf_data_i;
   logic                    nbf_last_i;
   bp_boot_pkg::mem_idx_t   mem_rd_addr_i;
   bp_boot_pkg::instr_idx_t instr_rd_addr_i;
   bp_boot_pkg::data_t      mem_rd_data_o;
   bp_boot_pkg::data_t      instr_rd_data_o;
   logic                    freeze_o;
   bp_boot_pkg::core_id_t   core_id_o;
   bp_boot_pkg::cce_mode_e  cce_mode_o;
   logic                    cfg_done_o;
   logic                    boot_done_o;
   logic                    nbf_full_o;

   // Reference model of memory, last write wins
   bp_boot_pkg::data_t exp_mem [int];
   int                 used_q [$];

   bp_boot_top bp_boot_top_inst
      (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .nbf_v_i         (nbf_v_i),
      .nbf_addr_i      (nbf_addr_i),
      .nbf_data_i      (nbf_data_i),
      .nbf_last_i      (nbf_last_i),
      .mem_rd_addr_i   (mem_rd_addr_i),
      .instr_rd_addr_i (instr_rd_addr_i),
      .mem_rd_data_o   (mem_rd_data_o),
      .instr_rd_data_o (instr_rd_data_o),
      .freeze_o        (freeze_o),
      .core_id_o       (core_id_o),
      .cce_mode_o      (cce_mode_o),
      .cfg_done_o      (cfg_done_o),
      .boot_done_o     (boot_done_o),
      .nbf_full_o      (nbf_full_o)
      );

   always #50 clk_i = ~clk_i;

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp)
      else
      begin
         $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
         $display("Errors found");
         $fatal(1);
      end
   endtask

   task automatic drive_nbf(input logic v, input bp_boot_pkg::addr_t addr,
                            input bp_boot_pkg::data_t data, input logic last);
      nbf_v_i    = v;
      nbf_addr_i = addr;
      nbf_data_i = data;
      nbf_last_i = last;
   endtask

   // About one record in four reuses an earlier address
   task automatic make_record(output bp_boot_pkg::addr_t addr, output bp_boot_pkg::data_t data);
      int pick;
      if (used_q.size() > 0 && $urandom_range(3, 0) == 0)
      begin
         pick = int'($urandom_range(used_q.size() - 1, 0));
         addr = 12'(used_q[pick]);
      end
      else
         addr = 12'($urandom_range(255, 0));
      data = {$urandom, $urandom};
      exp_mem[int'(addr)] = data;
      used_q.push_back(int'(addr));
   endtask

   initial
   begin
      repeat (watchdog_cycles) @(posedge clk_i);
      $display("Timeout: boot sequence and readback did not finish in time");
      $display("Errors found");
      $fatal(1);
   end

   initial
   begin
      int unsigned        seed_val;
      int                 n_pre;
      int                 sent;
      int                 gap;
      bp_boot_pkg::addr_t rec_addr;
      bp_boot_pkg::data_t rec_data;
      bp_boot_pkg::data_t exp_word;

      seed_val        = $urandom(32'he196);
      clk_i           = 1'b0;
      rst_i           = 1'b1;
      mem_rd_addr_i   = '0;
      instr_rd_addr_i = '0;
      drive_nbf(1'b0, '0, '0, 1'b0);
      sent            = 0;

      repeat (5) @(negedge clk_i);
      check_value("freeze_o", 64'(freeze_o), 64'(1));
      check_value("cfg_done_o", 64'(cfg_done_o), 64'(0));
      check_value("boot_done_o", 64'(boot_done_o), 64'(0));
      check_value("cce_mode_o", 64'(cce_mode_o), 64'(bp_boot_pkg::cce_uncached));
      check_value("core_id_o", 64'(core_id_o), 64'(0));
      check_value("nbf_full_o", 64'(nbf_full_o), 64'(0));
      rst_i = 1'b0;

      // Early records queue up while config is still being written
      n_pre = int'($urandom_range(max_pre, 0));
      for (int cyc = 1; cyc <= 20; cyc++)
      begin
         if (cyc < 20 && sent < n_pre &&
             ($urandom_range(1, 0) == 1 || n_pre - sent >= 20 - cyc))
         begin
            make_record(rec_addr, rec_data);
            drive_nbf(1'b1, rec_addr, rec_data, 1'b0);
            sent++;
         end
         else
            drive_nbf(1'b0, '0, '0, 1'b0);
         @(negedge clk_i);
         check_value("cfg_done_o", 64'(cfg_done_o), 64'(cyc >= 20));
         check_value("freeze_o", 64'(freeze_o), 64'(1));
         // Nothing drains before streaming starts, so occupancy is the count sent
         check_value("nbf_full_o", 64'(nbf_full_o), 64'(sent >= `BP_BOOT_NBF_DEPTH));
      end
      drive_nbf(1'b0, '0, '0, 1'b0);
      check_value("core_id_o", 64'(core_id_o), 64'(`BP_BOOT_CORE_ID));
      check_value("cce_mode_o", 64'(cce_mode_o), 64'(bp_boot_pkg::cce_normal));

      for (int rec = sent; rec < n_rec; rec++)
      begin
         make_record(rec_addr, rec_data);
         drive_nbf(1'b1, rec_addr, rec_data, rec == n_rec - 1);
         @(negedge clk_i);
         drive_nbf(1'b0, '0, '0, 1'b0);
         check_value("freeze_o", 64'(freeze_o), 64'(1));
         gap = (rec == n_rec - 1) ? 0 : int'($urandom_range(max_gap - 1, 0));
         repeat (gap)
         begin
            @(negedge clk_i);
            check_value("freeze_o", 64'(freeze_o), 64'(1));
         end
      end

      // Strobes past the last record must be dropped
      for (int k = 0; k < n_extra; k++)
      begin
         rec_addr = 12'(used_q[$urandom_range(used_q.size() - 1, 0)]);
         drive_nbf(1'b1, rec_addr, ~exp_mem[int'(rec_addr)], 1'b0);
         @(negedge clk_i);
         check_value("freeze_o", 64'(freeze_o), 64'(!boot_done_o));
      end
      drive_nbf(1'b0, '0, '0, 1'b0);

      while (boot_done_o !== 1'b1)
      begin
         check_value("freeze_o", 64'(freeze_o), 64'(1));
         @(negedge clk_i);
      end
      check_value("freeze_o", 64'(freeze_o), 64'(0));
      check_value("nbf_full_o", 64'(nbf_full_o), 64'(0));

      foreach (exp_mem[a])
      begin
         mem_rd_addr_i = 8'(a);
         @(negedge clk_i);
         check_value($sformatf("mem_rd_data_o[0x%02h]", a), mem_rd_data_o, exp_mem[a]);
      end

      for (int k = 0; k < `BP_BOOT_INSTR_ELS; k++)
      begin
         instr_rd_addr_i = 4'(k);
         @(negedge clk_i);
         exp_word = {`BP_BOOT_INSTR_TAG, 48'h0, 8'(k)};
         check_value($sformatf("instr_rd_data_o[%0d]", k), instr_rd_data_o, exp_word);
      end

      check_value("boot_done_o", 64'(boot_done_o), 64'(1));
      check_value("cfg_done_o", 64'(cfg_done_o), 64'(1));
      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/bp_boot_cfg_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_boot_params.svh"

module bp_boot_cfg_loader
   (
   input  logic               clk_i,
   input  logic               rst_i,
   output logic               cmd_v_o,
   output bp_boot_pkg::addr_t cmd_addr_o,
   output bp_boot_pkg::data_t cmd_data_o,
   output logic               done_o
   );

   bp_boot_pkg::cfg_state_e state_r;
   bp_boot_pkg::instr_idx_t instr_idx_r;
   logic                    done_r;
   bp_boot_pkg::data_t      instr_word;

   // Tag in the top byte, index zero-extended into the rest
   assign instr_word = {`BP_BOOT_INSTR_TAG, (`BP_BOOT_DATA_W-8)'(instr_idx_r)};

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_r     <= bp_boot_pkg::cfg_reset;
         instr_idx_r <= '0;
         done_r      <= 1'b0;
      end
      else
      begin
         case (state_r)
            bp_boot_pkg::cfg_reset:   state_r <= bp_boot_pkg::cfg_freeze;
            bp_boot_pkg::cfg_freeze:  state_r <= bp_boot_pkg::cfg_core_id;
            bp_boot_pkg::cfg_core_id: state_r <= bp_boot_pkg::cfg_mode;
            bp_boot_pkg::cfg_mode:    state_r <= bp_boot_pkg::cfg_instr;
            bp_boot_pkg::cfg_instr:
            begin
               instr_idx_r <= instr_idx_r + 1'b1;
               // Last instruction word goes out this cycle
               if (instr_idx_r == bp_boot_pkg::instr_idx_t'(`BP_BOOT_INSTR_ELS-1))
               begin
                  state_r <= bp_boot_pkg::cfg_done;
                  done_r  <= 1'b1;
               end
            end
            bp_boot_pkg::cfg_done:    state_r <= bp_boot_pkg::cfg_done;
            default:                  state_r <= bp_boot_pkg::cfg_reset;
         endcase
      end
   end

   always_comb
   begin
      cmd_v_o    = 1'b1;
      cmd_addr_o = '0;
      cmd_data_o = '0;
      case (state_r)
         bp_boot_pkg::cfg_freeze:
         begin
            cmd_addr_o = `BP_BOOT_FREEZE_ADDR;
            cmd_data_o = bp_boot_pkg::data_t'(1'b1);
         end
         bp_boot_pkg::cfg_core_id:
         begin
            cmd_addr_o = `BP_BOOT_CORE_ID_ADDR;
            cmd_data_o = bp_boot_pkg::data_t'(`BP_BOOT_CORE_ID);
         end
         bp_boot_pkg::cfg_mode:
         begin
            cmd_addr_o = `BP_BOOT_CCE_MODE_ADDR;
            cmd_data_o = bp_boot_pkg::data_t'(bp_boot_pkg::cce_normal);
         end
         bp_boot_pkg::cfg_instr:
         begin
            cmd_addr_o = bp_boot_pkg::addr_t'(`BP_BOOT_INSTR_BASE + instr_idx_r);
            cmd_data_o = instr_word;
         end
         default:
            cmd_v_o = 1'b0;
      endcase
   end

   assign done_o = done_r;

endmodule

`default_nettype wire

// ==== verilog/bp_boot_cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_boot_params.svh"

module bp_boot_cfg_regs
   (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic                    w_v_i,
   input  bp_boot_pkg::addr_t      w_addr_i,
   input  bp_boot_pkg::data_t      w_data_i,
   input  bp_boot_pkg::instr_idx_t instr_rd_addr_i,
   output logic                    freeze_o,
   output bp_boot_pkg::core_id_t   core_id_o,
   output bp_boot_pkg::cce_mode_e  cce_mode_o,
   output bp_boot_pkg::data_t      instr_rd_data_o
   );

   bp_boot_pkg::data_t instr_ram [`BP_BOOT_INSTR_ELS];
   bp_boot_pkg::addr_t instr_off;
   logic               instr_hit;

   // Offset into the CCE instruction window
   assign instr_off = w_addr_i - `BP_BOOT_INSTR_BASE;
   assign instr_hit = (w_addr_i >= `BP_BOOT_INSTR_BASE) && (instr_off < `BP_BOOT_INSTR_ELS);

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         freeze_o   <= 1'b1;
         core_id_o  <= '0;
         cce_mode_o <= bp_boot_pkg::cce_uncached;
      end
      else if (w_v_i)
      begin
         case (w_addr_i)
            `BP_BOOT_FREEZE_ADDR:
               freeze_o <= w_data_i[0];
            `BP_BOOT_CORE_ID_ADDR:
               core_id_o <= bp_boot_pkg::core_id_t'(w_data_i);
            `BP_BOOT_CCE_MODE_ADDR:
               cce_mode_o <= bp_boot_pkg::cce_mode_e'(w_data_i[0]);
            // Unmapped config addresses drop the write
            default:
            begin
            end
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (w_v_i && instr_hit)
         instr_ram[bp_boot_pkg::instr_idx_t'(instr_off)] <= w_data_i;
      instr_rd_data_o <= instr_ram[instr_rd_addr_i];
   end

endmodule

`default_nettype wire

// ==== verilog/bp_boot_io_router.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_boot_params.svh"

module bp_boot_io_router
   (
   input  logic                  cfg_v_i,
   input  bp_boot_pkg::addr_t    cfg_addr_i,
   input  bp_boot_pkg::data_t    cfg_data_i,
   input  logic                  nbf_v_i,
   input  bp_boot_pkg::addr_t    nbf_addr_i,
   input  bp_boot_pkg::data_t    nbf_data_i,
   output logic                  reg_w_v_o,
   output bp_boot_pkg::addr_t    reg_w_addr_o,
   output bp_boot_pkg::data_t    reg_w_data_o,
   output logic                  mem_w_v_o,
   output bp_boot_pkg::mem_idx_t mem_w_idx_o,
   output bp_boot_pkg::data_t    mem_w_data_o
   );

   logic               sel_v;
   bp_boot_pkg::addr_t sel_addr;
   bp_boot_pkg::data_t sel_data;
   logic               is_cfg;

   // Loaders are mutually exclusive, so the active valid picks the source
   assign sel_v    = cfg_v_i | nbf_v_i;
   assign sel_addr = cfg_v_i ? cfg_addr_i : nbf_addr_i;
   assign sel_data = cfg_v_i ? cfg_data_i : nbf_data_i;

   assign is_cfg = (sel_addr >= `BP_BOOT_CFG_BASE);

   assign reg_w_v_o    = sel_v & is_cfg;
   assign reg_w_addr_o = sel_addr;
   assign reg_w_data_o = sel_data;

   // Memory sees only the low address bits
   assign mem_w_v_o    = sel_v & ~is_cfg;
   assign mem_w_idx_o  = bp_boot_pkg::mem_idx_t'(sel_addr);
   assign mem_w_data_o = sel_data;

endmodule

`default_nettype wire

// ==== verilog/bp_boot_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_boot_params.svh"

module bp_boot_mem
   (
   input  logic                  clk_i,
   input  logic                  w_v_i,
   input  bp_boot_pkg::mem_idx_t w_idx_i,
   input  bp_boot_pkg::data_t    w_data_i,
   input  bp_boot_pkg::mem_idx_t rd_idx_i,
   output bp_boot_pkg::data_t    rd_data_o
   );

   bp_boot_pkg::data_t mem_r [`BP_BOOT_MEM_ELS];

   always_ff @(posedge clk_i)
   begin
      if (w_v_i)
         mem_r[w_idx_i] <= w_data_i;
   end

   // Read data follows the index by one cycle
   always_ff @(posedge clk_i)
   begin
      rd_data_o <= mem_r[rd_idx_i];
   end

endmodule

`default_nettype wire

// ==== verilog/bp_boot_nbf_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_boot_params.svh"

module bp_boot_nbf_loader
   (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               cfg_done_i,
   input  logic               nbf_v_i,
   input  bp_boot_pkg::addr_t nbf_addr_i,
   input  bp_boot_pkg::data_t nbf_data_i,
   input  logic               nbf_last_i,
   output logic               cmd_v_o,
   output bp_boot_pkg::addr_t cmd_addr_o,
   output bp_boot_pkg::data_t cmd_data_o,
   output logic               fifo_full_o,
   output logic               boot_done_o
   );

   localparam int ptr_w = $clog2(`BP_BOOT_NBF_DEPTH);

   bp_boot_pkg::addr_t      fifo_addr_r [`BP_BOOT_NBF_DEPTH];
   bp_boot_pkg::data_t      fifo_data_r [`BP_BOOT_NBF_DEPTH];
   logic                    fifo_last_r [`BP_BOOT_NBF_DEPTH];
   logic [ptr_w-1:0]        wr_ptr_r;
   logic [ptr_w-1:0]        rd_ptr_r;
   logic [ptr_w:0]          count_r;
   logic                    last_seen_r;
   logic                    boot_done_r;
   bp_boot_pkg::nbf_state_e state_r;
   logic                    fifo_empty;
   logic                    push;
   logic                    pop;

   assign fifo_full_o = (count_r == `BP_BOOT_NBF_DEPTH);
   assign fifo_empty  = (count_r == '0);
   // Nothing is taken once the last record is in
   assign push = nbf_v_i & ~fifo_full_o & ~last_seen_r;
   assign pop  = (state_r == bp_boot_pkg::nbf_stream) & ~fifo_empty;

   always_ff @(posedge clk_i)
   begin
      if (push)
      begin
         fifo_addr_r[wr_ptr_r] <= nbf_addr_i;
         fifo_data_r[wr_ptr_r] <= nbf_data_i;
         fifo_last_r[wr_ptr_r] <= nbf_last_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         wr_ptr_r    <= '0;
         rd_ptr_r    <= '0;
         count_r     <= '0;
         last_seen_r <= 1'b0;
         boot_done_r <= 1'b0;
         state_r     <= bp_boot_pkg::nbf_wait;
      end
      else
      begin
         if (push)
         begin
            wr_ptr_r    <= (wr_ptr_r == ptr_w'(`BP_BOOT_NBF_DEPTH-1)) ? '0 : wr_ptr_r + 1'b1;
            last_seen_r <= nbf_last_i;
         end
         if (pop)
            rd_ptr_r <= (rd_ptr_r == ptr_w'(`BP_BOOT_NBF_DEPTH-1)) ? '0 : rd_ptr_r + 1'b1;
         if (push & ~pop)
            count_r <= count_r + 1'b1;
         else if (pop & ~push)
            count_r <= count_r - 1'b1;

         case (state_r)
            bp_boot_pkg::nbf_wait:
               if (cfg_done_i)
                  state_r <= bp_boot_pkg::nbf_stream;
            bp_boot_pkg::nbf_stream:
               if (pop && fifo_last_r[rd_ptr_r])
                  state_r <= bp_boot_pkg::nbf_unfreeze;
            bp_boot_pkg::nbf_unfreeze:
            begin
               state_r     <= bp_boot_pkg::nbf_done;
               boot_done_r <= 1'b1;
            end
            default:
               state_r <= bp_boot_pkg::nbf_done;
         endcase
      end
   end

   always_comb
   begin
      cmd_v_o    = pop;
      cmd_addr_o = fifo_addr_r[rd_ptr_r];
      cmd_data_o = fifo_data_r[rd_ptr_r];
      // Release the core after the final record
      if (state_r == bp_boot_pkg::nbf_unfreeze)
      begin
         cmd_v_o    = 1'b1;
         cmd_addr_o = `BP_BOOT_FREEZE_ADDR;
         cmd_data_o = '0;
      end
   end

   assign boot_done_o = boot_done_r;

endmodule

`default_nettype wire

// ==== verilog/bp_boot_params.svh ====
`ifndef BP_BOOT_PARAMS_SVH
`define BP_BOOT_PARAMS_SVH

// Command path and storage sizes
`define BP_BOOT_ADDR_W      12
`define BP_BOOT_DATA_W      64
`define BP_BOOT_MEM_ELS     256
`define BP_BOOT_INSTR_ELS   16
`define BP_BOOT_NBF_DEPTH   16

// Address map, everything below the config base lands in memory
`define BP_BOOT_CFG_BASE      12'h800
`define BP_BOOT_FREEZE_ADDR   12'h800
`define BP_BOOT_CORE_ID_ADDR  12'h801
`define BP_BOOT_CCE_MODE_ADDR 12'h802
`define BP_BOOT_INSTR_BASE    12'h810

// Boot constants
`define BP_BOOT_CORE_ID     8'h03
`define BP_BOOT_INSTR_TAG   8'hC5

`endif

// ==== verilog/bp_boot_pkg.sv ====
`default_nettype none

`include "bp_boot_params.svh"

package bp_boot_pkg;

   typedef logic [`BP_BOOT_ADDR_W-1:0]            addr_t;
   typedef logic [`BP_BOOT_DATA_W-1:0]            data_t;
   typedef logic [$clog2(`BP_BOOT_MEM_ELS)-1:0]   mem_idx_t;
   typedef logic [$clog2(`BP_BOOT_INSTR_ELS)-1:0] instr_idx_t;
   typedef logic [7:0]                            core_id_t;

   typedef enum logic
   {
      cce_uncached = 1'b0,
      cce_normal   = 1'b1
   } cce_mode_e;

   // Fixed config write sequence
   typedef enum logic [2:0]
   {
      cfg_reset,
      cfg_freeze,
      cfg_core_id,
      cfg_mode,
      cfg_instr,
      cfg_done
   } cfg_state_e;

   typedef enum logic [1:0]
   {
      nbf_wait,
      nbf_stream,
      nbf_unfreeze,
      nbf_done
   } nbf_state_e;

endpackage

`default_nettype wire

// ==== verilog/bp_boot_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bp_boot_top
   (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic                    nbf_v_i,
   input  bp_boot_pkg::addr_t      nbf_addr_i,
   input  bp_boot_pkg::data_t      nbf_data_i,
   input  logic                    nbf_last_i,
   input  bp_boot_pkg::mem_idx_t   mem_rd_addr_i,
   input  bp_boot_pkg::instr_idx_t instr_rd_addr_i,
   output bp_boot_pkg::data_t      mem_rd_data_o,
   output bp_boot_pkg::data_t      instr_rd_data_o,
   output logic                    freeze_o,
   output bp_boot_pkg::core_id_t   core_id_o,
   output bp_boot_pkg::cce_mode_e  cce_mode_o,
   output logic                    cfg_done_o,
   output logic                    boot_done_o,
   output logic                    nbf_full_o
   );

   logic                  cfg_cmd_v;
   bp_boot_pkg::addr_t    cfg_cmd_addr;
   bp_boot_pkg::data_t    cfg_cmd_data;
   logic                  nbf_cmd_v;
   bp_boot_pkg::addr_t    nbf_cmd_addr;
   bp_boot_pkg::data_t    nbf_cmd_data;
   logic                  reg_w_v;
   bp_boot_pkg::addr_t    reg_w_addr;
   bp_boot_pkg::data_t    reg_w_data;
   logic                  mem_w_v;
   bp_boot_pkg::mem_idx_t mem_w_idx;
   bp_boot_pkg::data_t    mem_w_data;

   bp_boot_cfg_loader cfg_loader_inst
      (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .cmd_v_o    (cfg_cmd_v),
      .cmd_addr_o (cfg_cmd_addr),
      .cmd_data_o (cfg_cmd_data),
      .done_o     (cfg_done_o)
      );

   // Program loader holds off until config is finished
   bp_boot_nbf_loader nbf_loader_inst
      (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .cfg_done_i  (cfg_done_o),
      .nbf_v_i     (nbf_v_i),
      .nbf_addr_i  (nbf_addr_i),
      .nbf_data_i  (nbf_data_i),
      .nbf_last_i  (nbf_last_i),
      .cmd_v_o     (nbf_cmd_v),
      .cmd_addr_o  (nbf_cmd_addr),
      .cmd_data_o  (nbf_cmd_data),
      .fifo_full_o (nbf_full_o),
      .boot_done_o (boot_done_o)
      );

   bp_boot_io_router io_router_inst
      (
      .cfg_v_i      (cfg_cmd_v),
      .cfg_addr_i   (cfg_cmd_addr),
      .cfg_data_i   (cfg_cmd_data),
      .nbf_v_i      (nbf_cmd_v),
      .nbf_addr_i   (nbf_cmd_addr),
      .nbf_data_i   (nbf_cmd_data),
      .reg_w_v_o    (reg_w_v),
      .reg_w_addr_o (reg_w_addr),
      .reg_w_data_o (reg_w_data),
      .mem_w_v_o    (mem_w_v),
      .mem_w_idx_o  (mem_w_idx),
      .mem_w_data_o (mem_w_data)
      );

   bp_boot_cfg_regs cfg_regs_inst
      (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .w_v_i           (reg_w_v),
      .w_addr_i        (reg_w_addr),
      .w_data_i        (reg_w_data),
      .instr_rd_addr_i (instr_rd_addr_i),
      .freeze_o        (freeze_o),
      .core_id_o       (core_id_o),
      .cce_mode_o      (cce_mode_o),
      .instr_rd_data_o (instr_rd_data_o)
      );

   bp_boot_mem mem_inst
      (
      .clk_i     (clk_i),
      .w_v_i     (mem_w_v),
      .w_idx_i   (mem_w_idx),
      .w_data_i  (mem_w_data),
      .rd_idx_i  (mem_rd_addr_i),
      .rd_data_o (mem_rd_data_o)
      );

endmodule

`default_nettype wire
